// ==== source/fdtd_cfg_pkg.sv ====
`default_nettype none

package fdtd_cfg_pkg;

    ////////////////////
    // memory side
    ////////////////////

    // word address, one location per field word
    localparam int ADDR_W = 16;

    // width of one Hy or Ez sample
    localparam int DATA_W = 32;

    ////////////////////
    // chunking
    ////////////////////

    // total words per field for one run
    localparam int SIZE_W = 16;

    // words moved per field before the compute side takes over
    localparam int BUFFER_WORDS = 8;

    // holds 0..BUFFER_WORDS
    localparam int CNT_W = 4;

endpackage : fdtd_cfg_pkg

`default_nettype wire

// ==== source/fdtd_types_pkg.sv ====
`default_nettype none

package fdtd_types_pkg;

    // field tag carried with every word
    typedef enum logic {
        FIELD_HY = 1'b0,
        FIELD_EZ = 1'b1
    } field_e;

    // sequencer phases, shared by all blocks
    typedef enum logic [2:0] {
        PH_IDLE      = 3'd0,
        PH_READ_HY   = 3'd1,
        PH_READ_EZ   = 3'd2,
        PH_WAIT_CALC = 3'd3,
        PH_WRITE_HY  = 3'd4,
        PH_WRITE_EZ  = 3'd5
    } phase_t;

    // read port request, address held while valid
    typedef struct packed {
        logic                              valid;
        logic [fdtd_cfg_pkg::ADDR_W-1:0]   addr;
    } mem_rd_req_t;

    // write port request, held until granted
    typedef struct packed {
        logic                              valid;
        logic [fdtd_cfg_pkg::ADDR_W-1:0]   addr;
        logic [fdtd_cfg_pkg::DATA_W-1:0]   data;
    } mem_wr_req_t;

    // word handed to the compute side
    typedef struct packed {
        logic                              valid;
        field_e                            field;
        logic [fdtd_cfg_pkg::DATA_W-1:0]   data;
    } fld_word_t;

    // run setup, sampled on start
    typedef struct packed {
        logic [fdtd_cfg_pkg::ADDR_W-1:0]   hy_base;
        logic [fdtd_cfg_pkg::ADDR_W-1:0]   ez_base;
        logic [fdtd_cfg_pkg::SIZE_W-1:0]   size;
    } ctrl_cfg_t;

endpackage : fdtd_types_pkg

`default_nettype wire

// ==== source/fdtd_seq_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module fdtd_seq_fsm
(
    input  wire logic                    ACLK,
    input  wire logic                    ARESETn,

    input  wire logic                    start_i,
    input  wire logic                    size_zero_i,
    input  wire logic                    calc_done_i,
    input  wire logic                    chunk_done_i,
    input  wire logic                    all_done_i,
    input  wire logic                    int_en_i,
    input  wire logic                    int_clr_i,

    output fdtd_types_pkg::phase_t       phase_o,
    output logic                         busy_o,
    output logic                         buffer_full_o,
    output logic                         int_pending_o,
    output logic                         int_o
);

    import fdtd_types_pkg::*;

    phase_t phase_q;
    phase_t phase_d;
    logic   busy_q;

    ////////////////////
    // phase sequencing
    ////////////////////

    always_comb
    begin
        phase_d = phase_q;
        case (phase_q)
            PH_IDLE:
            begin
                // empty runs never leave idle
                if (start_i && !size_zero_i)
                    phase_d = PH_READ_HY;
            end
            PH_READ_HY:
            begin
                if (chunk_done_i)
                    phase_d = PH_READ_EZ;
            end
            PH_READ_EZ:
            begin
                if (chunk_done_i)
                    phase_d = PH_WAIT_CALC;
            end
            PH_WAIT_CALC:
            begin
                if (calc_done_i)
                    phase_d = PH_WRITE_HY;
            end
            PH_WRITE_HY:
            begin
                if (chunk_done_i)
                    phase_d = PH_WRITE_EZ;
            end
            PH_WRITE_EZ:
            begin
                // last chunk written back, otherwise fetch the next one
                if (chunk_done_i)
                    phase_d = all_done_i ? PH_IDLE : PH_READ_HY;
            end
            default:
            begin
                phase_d = PH_IDLE;
            end
        endcase
    end

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
            phase_q <= PH_IDLE;
        else
            phase_q <= phase_d;
    end

    assign phase_o = phase_q;
    assign busy_o  = (phase_q != PH_IDLE);

    // high for the first wait cycle only
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
            buffer_full_o <= 1'b0;
        else
            buffer_full_o <= (phase_q == PH_READ_EZ) && chunk_done_i;
    end

    ////////////////////
    // interrupt
    ////////////////////

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
            busy_q <= 1'b0;
        else
            busy_q <= busy_o;
    end

    // falling busy sets pending, a clear in the same cycle wins
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
            int_pending_o <= 1'b0;
        else if (int_clr_i)
            int_pending_o <= 1'b0;
        else if (busy_q && !busy_o)
            int_pending_o <= 1'b1;
    end

    assign int_o = int_pending_o & int_en_i;

endmodule : fdtd_seq_fsm

`default_nettype wire

// ==== source/fdtd_word_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module fdtd_word_counter
(
    input  wire logic                            ACLK,
    input  wire logic                            ARESETn,

    input  wire fdtd_types_pkg::phase_t          phase_i,
    input  wire logic                            start_i,
    input  wire logic [fdtd_cfg_pkg::SIZE_W-1:0] size_i,
    input  wire logic                            rd_gnt_i,
    input  wire logic                            wr_gnt_i,

    output logic                                 size_zero_o,
    output logic                                 chunk_done_o,
    output logic                                 all_done_o
);

    import fdtd_cfg_pkg::*;
    import fdtd_types_pkg::*;

    logic [SIZE_W-1:0] remain_q;
    logic [CNT_W-1:0]  cnt_q;
    logic [CNT_W-1:0]  chunk_len;
    logic              rd_phase;
    logic              wr_phase;
    logic              gnt;

    assign rd_phase = (phase_i == PH_READ_HY) || (phase_i == PH_READ_EZ);
    assign wr_phase = (phase_i == PH_WRITE_HY) || (phase_i == PH_WRITE_EZ);

    // grant that belongs to the running transfer
    assign gnt = (rd_phase && rd_gnt_i) || (wr_phase && wr_gnt_i);

    // last chunk may be short
    assign chunk_len = (remain_q < SIZE_W'(BUFFER_WORDS)) ? remain_q[CNT_W-1:0]
                                                          : CNT_W'(BUFFER_WORDS);

    assign size_zero_o  = (size_i == '0);
    assign chunk_done_o = gnt && (cnt_q == chunk_len - CNT_W'(1));
    assign all_done_o   = chunk_done_o && (phase_i == PH_WRITE_EZ)
                          && (remain_q == SIZE_W'(chunk_len));

    // grants seen in the current phase
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
            cnt_q <= '0;
        else if (chunk_done_o || !(rd_phase || wr_phase))
            cnt_q <= '0;
        else if (gnt)
            cnt_q <= cnt_q + CNT_W'(1);
    end

    // words still to be processed, per field
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
            remain_q <= '0;
        else if (start_i && (phase_i == PH_IDLE) && !size_zero_o)
            remain_q <= size_i;
        else if (chunk_done_o && (phase_i == PH_WRITE_EZ))
            remain_q <= remain_q - SIZE_W'(chunk_len);
    end

endmodule : fdtd_word_counter

`default_nettype wire

// ==== source/fdtd_addr_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module fdtd_addr_gen
(
    input  wire logic                            ACLK,
    input  wire logic                            ARESETn,

    input  wire fdtd_types_pkg::phase_t          phase_i,
    input  wire logic                            start_i,
    input  wire fdtd_types_pkg::ctrl_cfg_t       cfg_i,
    input  wire logic                            rd_gnt_i,
    input  wire logic                            wr_gnt_i,

    output fdtd_types_pkg::mem_rd_req_t          rd_req_o,
    output logic [fdtd_cfg_pkg::ADDR_W-1:0]      wr_addr_o
);

    import fdtd_cfg_pkg::*;
    import fdtd_types_pkg::*;

    logic [ADDR_W-1:0] rd_hy_q;
    logic [ADDR_W-1:0] rd_ez_q;
    logic [ADDR_W-1:0] wr_hy_q;
    logic [ADDR_W-1:0] wr_ez_q;
    logic              load;

    // pointers only reload from idle
    assign load = start_i && (phase_i == PH_IDLE);

    ////////////////////
    // read pointers
    ////////////////////

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            rd_hy_q <= '0;
            rd_ez_q <= '0;
        end
        else if (load)
        begin
            rd_hy_q <= cfg_i.hy_base;
            rd_ez_q <= cfg_i.ez_base;
        end
        else if (rd_gnt_i && (phase_i == PH_READ_HY))
            rd_hy_q <= rd_hy_q + ADDR_W'(1);
        else if (rd_gnt_i && (phase_i == PH_READ_EZ))
            rd_ez_q <= rd_ez_q + ADDR_W'(1);
    end

    ////////////////////
    // write pointers
    ////////////////////

    // trail the read pointers by one chunk
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            wr_hy_q <= '0;
            wr_ez_q <= '0;
        end
        else if (load)
        begin
            wr_hy_q <= cfg_i.hy_base;
            wr_ez_q <= cfg_i.ez_base;
        end
        else if (wr_gnt_i && (phase_i == PH_WRITE_HY))
            wr_hy_q <= wr_hy_q + ADDR_W'(1);
        else if (wr_gnt_i && (phase_i == PH_WRITE_EZ))
            wr_ez_q <= wr_ez_q + ADDR_W'(1);
    end

    assign rd_req_o.valid = (phase_i == PH_READ_HY) || (phase_i == PH_READ_EZ);
    assign rd_req_o.addr  = (phase_i == PH_READ_EZ) ? rd_ez_q : rd_hy_q;
    assign wr_addr_o      = (phase_i == PH_WRITE_EZ) ? wr_ez_q : wr_hy_q;

endmodule : fdtd_addr_gen

`default_nettype wire

// ==== source/fdtd_data_route.sv ====
`timescale 1ns/1ns
`default_nettype none

module fdtd_data_route
(
    input  wire logic                            ACLK,
    input  wire logic                            ARESETn,

    input  wire fdtd_types_pkg::phase_t          phase_i,
    input  wire logic                            rd_gnt_i,
    input  wire logic [fdtd_cfg_pkg::DATA_W-1:0] rd_data_i,
    input  wire logic [fdtd_cfg_pkg::DATA_W-1:0] upd_hy_i,
    input  wire logic [fdtd_cfg_pkg::DATA_W-1:0] upd_ez_i,
    input  wire logic [fdtd_cfg_pkg::ADDR_W-1:0] wr_addr_i,
    input  wire logic                            wr_gnt_i,

    output fdtd_types_pkg::fld_word_t            fld_rd_o,
    output fdtd_types_pkg::mem_wr_req_t          wr_req_o
);

    import fdtd_cfg_pkg::*;
    import fdtd_types_pkg::*;

    logic              rd_phase;
    logic              first_q;
    logic [DATA_W-1:0] upd_sel;
    logic [DATA_W-1:0] wr_data_q;

    assign rd_phase = (phase_i == PH_READ_HY) || (phase_i == PH_READ_EZ);

    // granted word goes out one cycle later with its phase tag
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            fld_rd_o.valid <= 1'b0;
            fld_rd_o.field <= FIELD_HY;
            fld_rd_o.data  <= '0;
        end
        else
        begin
            fld_rd_o.valid <= rd_phase && rd_gnt_i;
            fld_rd_o.field <= (phase_i == PH_READ_EZ) ? FIELD_EZ : FIELD_HY;
            if (rd_gnt_i)
                fld_rd_o.data <= rd_data_i;
        end
    end

    ////////////////////
    // write side
    ////////////////////

    assign upd_sel = (phase_i == PH_WRITE_EZ) ? upd_ez_i : upd_hy_i;

    // next cycle starts a new word after an idle or granted cycle
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
            first_q <= 1'b1;
        else
            first_q <= !wr_req_o.valid || wr_gnt_i;
    end

    // update word sampled on the first request cycle and held until granted
    always_ff @(posedge ACLK)
    begin
        if (first_q)
            wr_data_q <= upd_sel;
    end

    assign wr_req_o.valid = (phase_i == PH_WRITE_HY) || (phase_i == PH_WRITE_EZ);
    assign wr_req_o.addr  = wr_addr_i;
    assign wr_req_o.data  = first_q ? upd_sel : wr_data_q;

endmodule : fdtd_data_route

`default_nettype wire

// ==== source/fdtd_mem_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module fdtd_mem_ctrl
(
    input  wire logic                            ACLK,
    input  wire logic                            ARESETn,

    // control and status
    input  wire logic                            start_i,
    input  wire fdtd_types_pkg::ctrl_cfg_t       cfg_i,
    input  wire logic                            int_en_i,
    input  wire logic                            int_clr_i,
    output logic                                 busy_o,
    output logic                                 int_pending_o,
    output logic                                 int_o,
    output logic                                 buffer_full_o,

    // memory read port
    output fdtd_types_pkg::mem_rd_req_t          rd_req_o,
    input  wire logic                            rd_gnt_i,
    input  wire logic [fdtd_cfg_pkg::DATA_W-1:0] rd_data_i,

    // memory write port
    output fdtd_types_pkg::mem_wr_req_t          wr_req_o,
    input  wire logic                            wr_gnt_i,

    // compute side
    output fdtd_types_pkg::fld_word_t            fld_rd_o,
    input  wire logic                            calc_done_i,
    input  wire logic [fdtd_cfg_pkg::DATA_W-1:0] upd_hy_i,
    input  wire logic [fdtd_cfg_pkg::DATA_W-1:0] upd_ez_i
);

    import fdtd_cfg_pkg::*;
    import fdtd_types_pkg::*;

    phase_t            phase;
    logic              size_zero;
    logic              chunk_done;
    logic              all_done;
    logic [ADDR_W-1:0] wr_addr;

    fdtd_seq_fsm u_seq_fsm
    (
        .ACLK          ( ACLK          ),
        .ARESETn       ( ARESETn       ),
        .start_i       ( start_i       ),
        .size_zero_i   ( size_zero     ),
        .calc_done_i   ( calc_done_i   ),
        .chunk_done_i  ( chunk_done    ),
        .all_done_i    ( all_done      ),
        .int_en_i      ( int_en_i      ),
        .int_clr_i     ( int_clr_i     ),
        .phase_o       ( phase         ),
        .busy_o        ( busy_o        ),
        .buffer_full_o ( buffer_full_o ),
        .int_pending_o ( int_pending_o ),
        .int_o         ( int_o         )
    );

    fdtd_word_counter u_word_counter
    (
        .ACLK         ( ACLK       ),
        .ARESETn      ( ARESETn    ),
        .phase_i      ( phase      ),
        .start_i      ( start_i    ),
        .size_i       ( cfg_i.size ),
        .rd_gnt_i     ( rd_gnt_i   ),
        .wr_gnt_i     ( wr_gnt_i   ),
        .size_zero_o  ( size_zero  ),
        .chunk_done_o ( chunk_done ),
        .all_done_o   ( all_done   )
    );

    fdtd_addr_gen u_addr_gen
    (
        .ACLK      ( ACLK     ),
        .ARESETn   ( ARESETn  ),
        .phase_i   ( phase    ),
        .start_i   ( start_i  ),
        .cfg_i     ( cfg_i    ),
        .rd_gnt_i  ( rd_gnt_i ),
        .wr_gnt_i  ( wr_gnt_i ),
        .rd_req_o  ( rd_req_o ),
        .wr_addr_o ( wr_addr  )
    );

    fdtd_data_route u_data_route
    (
        .ACLK      ( ACLK      ),
        .ARESETn   ( ARESETn   ),
        .phase_i   ( phase     ),
        .rd_gnt_i  ( rd_gnt_i  ),
        .rd_data_i ( rd_data_i ),
        .upd_hy_i  ( upd_hy_i  ),
        .upd_ez_i  ( upd_ez_i  ),
        .wr_addr_i ( wr_addr   ),
        .wr_gnt_i  ( wr_gnt_i  ),
        .fld_rd_o  ( fld_rd_o  ),
        .wr_req_o  ( wr_req_o  )
    );

endmodule : fdtd_mem_ctrl

`default_nettype wire

// ==== sim/fdtd_tb_tasks.svh ====
`ifndef FDTD_TB_TASKS_SVH
`define FDTD_TB_TASKS_SVH

////////////////////
// helpers
////////////////////

function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
endfunction

// 0 to 3 idle cycles before a grant
function automatic int grant_delay();
    logic [31:0] r;
    r = next_rand();
    return int'(r[17:16]);
endfunction

// every address bit shows up in the word
function automatic logic [DATA_W-1:0] fill_value(input logic [15:0] a);
    return {~a, a} ^ 32'h3c96a50f;
endfunction

task automatic fill_memory();
    for (int a = 0; a < MEM_WORDS; a++)
    begin
        mem[a]     = fill_value(16'(a));
        ref_mem[a] = mem[a];
    end
endtask

task automatic check_value(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    if (got !== exp)
    begin
        $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        $display("Something failed");
        $fatal(1, "stopped at first error");
    end
endtask

task automatic pulse_start();
    start_i = 1'b1;
    @(posedge ACLK);
    #2;
    start_i = 1'b0;
endtask

// one full run, reads and memory compared afterwards
task automatic run_block(input logic [15:0] hy_base, input logic [15:0] ez_base,
                         input logic [15:0] size, input logic poke_start);
    logic [DATA_W-1:0] exp_data [$];
    field_e            exp_field [$];
    ctrl_cfg_t         saved;
    int                chunk;
    int                base;
    int                full_start;
    // expected read order, chunk by chunk with Hy before Ez
    for (base = 0; base < size; base += BUFFER_WORDS)
    begin
        chunk = (size - base < BUFFER_WORDS) ? size - base : BUFFER_WORDS;
        for (int i = 0; i < chunk; i++)
        begin
            exp_field.push_back(FIELD_HY);
            exp_data.push_back(ref_mem[hy_base + base + i]);
        end
        for (int i = 0; i < chunk; i++)
        begin
            exp_field.push_back(FIELD_EZ);
            exp_data.push_back(ref_mem[ez_base + base + i]);
        end
    end
    for (int i = 0; i < size; i++)
    begin
        ref_mem[hy_base + i] = ref_mem[hy_base + i] + 32'd1;
        ref_mem[ez_base + i] = ref_mem[ez_base + i] ^ 32'h5a5a5a5a;
    end
    got_field.delete();
    got_data.delete();
    full_start = full_count;
    @(posedge ACLK);
    #2;
    cfg_i.hy_base = hy_base;
    cfg_i.ez_base = ez_base;
    cfg_i.size    = size;
    pulse_start();
    check_value("busy_o", busy_o, 1'b1);
    if (poke_start)
    begin
        // second start with other bases, must be ignored
        repeat (6) @(posedge ACLK);
        #2;
        saved         = cfg_i;
        cfg_i.hy_base = 16'h0020;
        cfg_i.ez_base = 16'h0060;
        cfg_i.size    = 16'd4;
        pulse_start();
        cfg_i = saved;
    end
    while (busy_o)
    begin
        @(posedge ACLK);
        #2;
    end
    check_value("read word count", got_data.size(), exp_data.size());
    for (int i = 0; i < exp_data.size(); i++)
    begin
        check_value("fld_rd_o.field", got_field[i], exp_field[i]);
        check_value("fld_rd_o.data", got_data[i], exp_data[i]);
    end
    check_value("buffer_full_o pulses", full_count - full_start,
                (size + BUFFER_WORDS - 1) / BUFFER_WORDS);
    for (int a = 0; a < MEM_WORDS; a++)
    begin
        if (mem[a] !== ref_mem[a])
            check_value($sformatf("mem[0x%0h]", a), mem[a], ref_mem[a]);
    end
endtask

////////////////////
// directed tests
////////////////////

task automatic test_reset_values();
    check_value("busy_o", busy_o, 1'b0);
    check_value("int_o", int_o, 1'b0);
    check_value("int_pending_o", int_pending_o, 1'b0);
    check_value("buffer_full_o", buffer_full_o, 1'b0);
    check_value("rd_req_o.valid", rd_req_o.valid, 1'b0);
    check_value("wr_req_o.valid", wr_req_o.valid, 1'b0);
    check_value("fld_rd_o.valid", fld_rd_o.valid, 1'b0);
endtask

task automatic test_single_chunk();
    run_block(16'h0010, 16'h0040, 16'd5, 1'b0);
endtask

task automatic test_multi_chunk();
    run_block(16'h0100, 16'h0180, 16'd20, 1'b0);
endtask

task automatic test_interrupt();
    // drop what earlier runs left pending
    int_en_i  = 1'b0;
    int_clr_i = 1'b1;
    @(posedge ACLK);
    #2;
    int_clr_i = 1'b0;
    check_value("int_pending_o", int_pending_o, 1'b0);
    run_block(16'h0200, 16'h0210, 16'd3, 1'b0);
    // busy just fell, pending follows one cycle later
    check_value("int_pending_o", int_pending_o, 1'b0);
    @(posedge ACLK);
    #2;
    check_value("int_pending_o", int_pending_o, 1'b1);
    check_value("int_o", int_o, 1'b0);
    int_en_i = 1'b1;
    #1;
    check_value("int_o", int_o, 1'b1);
    @(posedge ACLK);
    #2;
    int_clr_i = 1'b1;
    @(posedge ACLK);
    #2;
    int_clr_i = 1'b0;
    check_value("int_pending_o", int_pending_o, 1'b0);
    check_value("int_o", int_o, 1'b0);
    int_en_i = 1'b0;
endtask

task automatic test_ignored_starts();
    @(posedge ACLK);
    #2;
    cfg_i.size = '0;
    pulse_start();
    check_value("busy_o", busy_o, 1'b0);
    check_value("rd_req_o.valid", rd_req_o.valid, 1'b0);
    run_block(16'h0300, 16'h0340, 16'd12, 1'b1);
endtask

`endif

// ==== sim/fdtd_mem_ctrl_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module fdtd_mem_ctrl_tb;

    import fdtd_cfg_pkg::*;
    import fdtd_types_pkg::*;

    localparam int MEM_WORDS = 1024;

    // every word is read and written once per field
    localparam int TOTAL_WORDS = 4 * (5 + 20 + 3 + 12);
    localparam int MAX_CYCLES  = TOTAL_WORDS * 10 + 400;

    logic              ACLK;
    logic              ARESETn;
    logic              start_i;
    ctrl_cfg_t         cfg_i;
    logic              int_en_i;
    logic              int_clr_i;
    logic              busy_o;
    logic              int_pending_o;
    logic              int_o;
    logic              buffer_full_o;
    mem_rd_req_t       rd_req_o;
    logic              rd_gnt_i;
    logic [DATA_W-1:0] rd_data_i;
    mem_wr_req_t       wr_req_o;
    logic              wr_gnt_i;
    fld_word_t         fld_rd_o;
    logic              calc_done_i;
    logic [DATA_W-1:0] upd_hy_i;
    logic [DATA_W-1:0] upd_ez_i;

    logic [DATA_W-1:0] mem [0:MEM_WORDS-1];
    logic [DATA_W-1:0] ref_mem [0:MEM_WORDS-1];
    logic [31:0]       rand_state;
    int                rd_wait;
    int                wr_wait;
    int                calc_wait;
    int                cycles;
    int                full_count;
    logic              rd_gnt_seen;
    field_e            got_field [$];
    logic [DATA_W-1:0] got_data [$];

    `include "fdtd_tb_tasks.svh"

    initial
    begin
        ACLK = 1'b0;
    end

    always #20 ACLK = ~ACLK;

    fdtd_mem_ctrl dut0
    (
        .ACLK          ( ACLK          ),
        .ARESETn       ( ARESETn       ),
        .start_i       ( start_i       ),
        .cfg_i         ( cfg_i         ),
        .int_en_i      ( int_en_i      ),
        .int_clr_i     ( int_clr_i     ),
        .busy_o        ( busy_o        ),
        .int_pending_o ( int_pending_o ),
        .int_o         ( int_o         ),
        .buffer_full_o ( buffer_full_o ),
        .rd_req_o      ( rd_req_o      ),
        .rd_gnt_i      ( rd_gnt_i      ),
        .rd_data_i     ( rd_data_i     ),
        .wr_req_o      ( wr_req_o      ),
        .wr_gnt_i      ( wr_gnt_i      ),
        .fld_rd_o      ( fld_rd_o      ),
        .calc_done_i   ( calc_done_i   ),
        .upd_hy_i      ( upd_hy_i      ),
        .upd_ez_i      ( upd_ez_i      )
    );

    ////////////////////
    // memory and compute models
    ////////////////////

    always @(posedge ACLK)
    begin
        #2;
        rd_gnt_i    = 1'b0;
        wr_gnt_i    = 1'b0;
        calc_done_i = 1'b0;
        // updates follow the write address, changed only after a grant edge
        upd_hy_i = mem[wr_req_o.addr] + 32'd1;
        upd_ez_i = mem[wr_req_o.addr] ^ 32'h5a5a5a5a;
        if (rd_req_o.valid)
        begin
            if (rd_wait == 0)
            begin
                rd_gnt_i  = 1'b1;
                rd_data_i = mem[rd_req_o.addr];
                rd_wait   = grant_delay();
            end
            else
                rd_wait--;
        end
        if (wr_req_o.valid)
        begin
            if (wr_wait == 0)
            begin
                wr_gnt_i = 1'b1;
                wr_wait  = grant_delay();
            end
            else
                wr_wait--;
        end
        if (buffer_full_o)
            calc_wait = grant_delay() + 1;
        if (calc_wait > 0)
        begin
            calc_wait--;
            calc_done_i = (calc_wait == 0);
        end
    end

    // outputs are settled mid-cycle
    always @(negedge ACLK)
    begin
        if (ARESETn)
        begin
            if (wr_gnt_i && (wr_req_o.addr < MEM_WORDS))
                mem[wr_req_o.addr] = wr_req_o.data;
            check_value("fld_rd_o.valid", fld_rd_o.valid, rd_gnt_seen);
            if (fld_rd_o.valid)
            begin
                got_field.push_back(fld_rd_o.field);
                got_data.push_back(fld_rd_o.data);
            end
            rd_gnt_seen = rd_gnt_i;
            if (buffer_full_o)
                full_count++;
        end
    end

    always @(posedge ACLK)
    begin
        cycles++;
        if (cycles > MAX_CYCLES)
        begin
            $display("timeout: the run hung, still going after %0d cycles", cycles);
            $display("Something failed");
            $fatal(1, "no progress");
        end
    end

    ////////////////////
    // test sequence
    ////////////////////

    initial
    begin
        rand_state  = 32'hce8fce0c;
        ARESETn     = 1'b0;
        start_i     = 1'b0;
        cfg_i       = '0;
        int_en_i    = 1'b0;
        int_clr_i   = 1'b0;
        rd_gnt_i    = 1'b0;
        rd_data_i   = '0;
        wr_gnt_i    = 1'b0;
        calc_done_i = 1'b0;
        upd_hy_i    = '0;
        upd_ez_i    = '0;
        rd_wait     = 0;
        wr_wait     = 0;
        calc_wait   = 0;
        cycles      = 0;
        full_count  = 0;
        rd_gnt_seen = 1'b0;
        fill_memory();
        repeat (2) @(posedge ACLK);
        #2;
        ARESETn = 1'b1;
        test_reset_values();
        test_single_chunk();
        test_multi_chunk();
        test_interrupt();
        test_ignored_starts();
        $display("Everything OK");
        $finish;
    end

endmodule : fdtd_mem_ctrl_tb

`default_nettype wire

// ==== build.f ====
+incdir+sim
source/fdtd_cfg_pkg.sv
source/fdtd_types_pkg.sv
source/fdtd_seq_fsm.sv
source/fdtd_word_counter.sv
source/fdtd_addr_gen.sv
source/fdtd_data_route.sv
source/fdtd_mem_ctrl.sv
sim/fdtd_mem_ctrl_tb.sv
